//--- pdemux_pkg.sv
package pdemux_pkg;

  //****************************************
  // Request destinations and PE FSM states
  //****************************************

  // Target of a core request
  typedef enum logic [1:0]
  {
    DEST_SH,   // Shared TCDM interconnect
    DEST_PE,   // Peripheral interconnect
    DEST_EXT   // External demux peripherals
  } dest_e;

  // One PE transaction at a time
  typedef enum logic [1:0]
  {
    PE_IDLE,     // Waiting for a PE request
    PE_PENDING,  // Request taken, response outstanding
    PE_GRANTED   // Response seen, core grant this cycle
  } pe_state_e;

  //****************************************
  // Address map
  //****************************************

  // Segment field, 1 MB per segment
  localparam int SEG_HI = 31;
  localparam int SEG_LO = 20;
  localparam int SEG_W  = 12;

  // Inside the DEM_PER segment this bit selects EXT over PE
  localparam int EXT_SEL_BIT = 14;

  // Nibble swapped by the address remap
  localparam int NIBBLE_HI = 31;
  localparam int NIBBLE_LO = 28;

  // Swapped with base_addr_i when the remap is on
  localparam logic [3:0] REMAP_NIBBLE = 4'h1;

endpackage

//--- pdemux_req_router.sv
`timescale 1ns/1ps

module pdemux_req_router
#(
  parameter int          ADDR_WIDTH         = 32,
  parameter int          DATA_WIDTH         = 32,
  parameter int          BE_WIDTH           = DATA_WIDTH/8,
  parameter int          REMAP_ADDRESS      = 0,
  parameter int          CLUSTER_ALIAS      = 1,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000
)
(
  input  logic [3:0]              base_addr_i,
  input  logic [5:0]              cluster_id_i,

  input  logic                    data_req_i,
  input  logic [ADDR_WIDTH-1:0]   data_add_i,
  input  logic                    data_wen_i,
  input  logic [DATA_WIDTH-1:0]   data_wdata_i,
  input  logic [BE_WIDTH-1:0]     data_be_i,
  output logic                    data_gnt_o,

  // Payload shared by all three targets
  output logic [ADDR_WIDTH-1:0]   data_add_o,
  output logic                    data_wen_o,
  output logic [DATA_WIDTH-1:0]   data_wdata_o,
  output logic [BE_WIDTH-1:0]     data_be_o,

  output logic                    sh_req_o,
  input  logic                    sh_gnt_i,
  output logic                    ext_req_o,
  input  logic                    ext_gnt_i,
  output logic                    pe_req_o,    // To the PE bridge
  input  logic                    pe_gnt_i,    // Core grant from the PE bridge

  output pdemux_pkg::dest_e       dest_o,

  output logic                    perf_l2_ld_o,
  output logic                    perf_l2_st_o,
  output logic                    perf_l2_ld_cyc_o,
  output logic                    perf_l2_st_cyc_o
);

  localparam bit ALIAS_EN = (CLUSTER_ALIAS == 1);
  localparam logic [pdemux_pkg::SEG_W-1:0] ALIAS_DEM_PER = CLUSTER_ALIAS_BASE + 12'd2;

  logic [3:0]                    add_top;
  logic [ADDR_WIDTH-1:0]         data_add_int;
  logic [pdemux_pkg::SEG_W-1:0]  seg;
  logic [pdemux_pkg::SEG_W-1:0]  tcdm_rw;
  logic [pdemux_pkg::SEG_W-1:0]  dem_per;
  logic                          sh_hit;
  logic                          ext_hit;
  logic                          sel_gnt;
  logic                          l2_req;

  //****************************************
  // Address remap
  //****************************************
  generate
    if (REMAP_ADDRESS == 1)
    begin : gen_remap
      always_comb
      begin
        add_top = data_add_i[pdemux_pkg::NIBBLE_HI:pdemux_pkg::NIBBLE_LO];
        if (data_add_i[pdemux_pkg::NIBBLE_HI:pdemux_pkg::NIBBLE_LO] == base_addr_i)
          add_top = pdemux_pkg::REMAP_NIBBLE;   // Cluster base seen as 0x1
        else if (data_add_i[pdemux_pkg::NIBBLE_HI:pdemux_pkg::NIBBLE_LO] ==
                 pdemux_pkg::REMAP_NIBBLE)
          add_top = base_addr_i;                // 0x1 seen as cluster base
      end
    end
    else
    begin : gen_no_remap
      assign add_top = data_add_i[pdemux_pkg::NIBBLE_HI:pdemux_pkg::NIBBLE_LO];
    end
  endgenerate

  assign data_add_int = {add_top, data_add_i[pdemux_pkg::NIBBLE_LO-1:0]};
  assign seg          = data_add_int[pdemux_pkg::SEG_HI:pdemux_pkg::SEG_LO];

  //****************************************
  // Destination decode
  //****************************************
  // Four segments per cluster, TCDM_TS shares bits 11:1 with TCDM_RW
  assign tcdm_rw = {base_addr_i, 8'h00} + {4'h0, cluster_id_i, 2'b00};
  assign dem_per = tcdm_rw + 12'd2;

  assign sh_hit  = (seg[pdemux_pkg::SEG_W-1:1] == tcdm_rw[pdemux_pkg::SEG_W-1:1]) ||
                   (ALIAS_EN &&
                    (seg[pdemux_pkg::SEG_W-1:1] == CLUSTER_ALIAS_BASE[pdemux_pkg::SEG_W-1:1]));
  assign ext_hit = ((seg == dem_per) || (ALIAS_EN && (seg == ALIAS_DEM_PER))) &&
                   data_add_int[pdemux_pkg::EXT_SEL_BIT];

  always_comb
  begin
    if (sh_hit)
      dest_o = pdemux_pkg::DEST_SH;
    else if (ext_hit)
      dest_o = pdemux_pkg::DEST_EXT;
    else
      dest_o = pdemux_pkg::DEST_PE;   // Rest of the memory map
  end

  //****************************************
  // Request and grant steering
  //****************************************
  assign sh_req_o  = data_req_i & (dest_o == pdemux_pkg::DEST_SH);
  assign ext_req_o = data_req_i & (dest_o == pdemux_pkg::DEST_EXT);
  assign pe_req_o  = data_req_i & (dest_o == pdemux_pkg::DEST_PE);

  always_comb
  begin
    case (dest_o)
      pdemux_pkg::DEST_SH:  sel_gnt = sh_gnt_i;
      pdemux_pkg::DEST_EXT: sel_gnt = ext_gnt_i;
      default:              sel_gnt = pe_gnt_i;
    endcase
  end

  assign data_gnt_o   = data_req_i & sel_gnt;

  assign data_add_o   = data_add_int;
  assign data_wen_o   = data_wen_i;
  assign data_wdata_o = data_wdata_i;
  assign data_be_o    = data_be_i;

  // L2 level means EXT or PE
  assign l2_req = data_req_i & (dest_o != pdemux_pkg::DEST_SH);

  assign perf_l2_ld_o     = l2_req & sel_gnt & data_wen_i;
  assign perf_l2_st_o     = l2_req & sel_gnt & ~data_wen_i;
  assign perf_l2_ld_cyc_o = l2_req & data_wen_i;    // Includes stalled cycles
  assign perf_l2_st_cyc_o = l2_req & ~data_wen_i;

endmodule

//--- pdemux_pe_bridge.sv
`timescale 1ns/1ps

module pdemux_pe_bridge
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic                    clk,
  input  logic                    rst_ni,

  // From the router
  input  logic                    pe_req_i,
  output logic                    pe_gnt_o,

  // PE port
  output logic                    pe_port_req_o,
  input  logic                    pe_port_gnt_i,
  input  logic                    pe_port_r_valid_i,
  input  logic [DATA_WIDTH-1:0]   pe_port_r_rdata_i,
  input  logic                    pe_port_r_opc_i,

  // Towards the response merge
  output logic                    pe_rsp_valid_o,
  output logic [DATA_WIDTH-1:0]   pe_rsp_rdata_o,
  output logic                    pe_rsp_opc_o
);

  pdemux_pkg::pe_state_e  state_q;
  pdemux_pkg::pe_state_e  state_d;

  logic                   valid0_q;
  logic [DATA_WIDTH-1:0]  rdata0_q;
  logic                   opc0_q;
  logic                   valid1_q;
  logic [DATA_WIDTH-1:0]  rdata1_q;
  logic                   opc1_q;

  //****************************************
  // PE transaction FSM
  //****************************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= pdemux_pkg::PE_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d       = state_q;
    pe_port_req_o = 1'b0;
    pe_gnt_o      = 1'b0;

    case (state_q)
      pdemux_pkg::PE_IDLE:
      begin
        pe_port_req_o = pe_req_i;
        if (pe_req_i && pe_port_gnt_i)
          state_d = pdemux_pkg::PE_PENDING;
      end

      pdemux_pkg::PE_PENDING:
      begin
        // Latency set by the peripheral
        if (pe_port_r_valid_i)
          state_d = pdemux_pkg::PE_GRANTED;
      end

      pdemux_pkg::PE_GRANTED:
      begin
        pe_gnt_o = 1'b1;   // Core grant once the response is back
        state_d  = pdemux_pkg::PE_IDLE;
      end

      default:
      begin
        state_d = pdemux_pkg::PE_IDLE;
      end
    endcase
  end

  //****************************************
  // Response pipeline, two stages
  //****************************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
    end
    else
    begin
      valid0_q <= pe_port_r_valid_i;
      valid1_q <= valid0_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pe_port_r_valid_i)
    begin
      rdata0_q <= pe_port_r_rdata_i;
      opc0_q   <= pe_port_r_opc_i;
    end
    if (valid0_q)
    begin
      rdata1_q <= rdata0_q;
      opc1_q   <= opc0_q;
    end
  end

  assign pe_rsp_valid_o = valid1_q;   // Two cycles after the PE r_valid
  assign pe_rsp_rdata_o = rdata1_q;
  assign pe_rsp_opc_o   = opc1_q;

endmodule

//--- pdemux_resp_merge.sv
`timescale 1ns/1ps

module pdemux_resp_merge
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic                    clk,
  input  logic                    rst_ni,

  input  logic                    data_req_i,
  input  pdemux_pkg::dest_e       dest_i,

  input  logic                    sh_r_valid_i,
  input  logic [DATA_WIDTH-1:0]   sh_r_rdata_i,
  input  logic                    ext_r_valid_i,
  input  logic [DATA_WIDTH-1:0]   ext_r_rdata_i,
  input  logic                    ext_r_opc_i,
  input  logic                    pe_rsp_valid_i,
  input  logic [DATA_WIDTH-1:0]   pe_rsp_rdata_i,
  input  logic                    pe_rsp_opc_i,

  output logic                    data_r_valid_o,
  output logic [DATA_WIDTH-1:0]   data_r_rdata_o,
  output logic                    data_r_opc_o
);

  pdemux_pkg::dest_e  dest_q;   // Target of the last request

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      dest_q <= pdemux_pkg::DEST_SH;
    else if (data_req_i)
      dest_q <= dest_i;
  end

  //****************************************
  // Response select
  //****************************************
  always_comb
  begin
    case (dest_q)
      pdemux_pkg::DEST_PE:
      begin
        data_r_valid_o = pe_rsp_valid_i;
        data_r_rdata_o = pe_rsp_rdata_i;
        data_r_opc_o   = pe_rsp_opc_i;
      end
      pdemux_pkg::DEST_EXT:
      begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      default:
      begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;         // TCDM never errors
      end
    endcase
  end

endmodule

//--- data_periph_demux.sv
`timescale 1ns/1ps

module data_periph_demux
#(
  parameter int          ADDR_WIDTH         = 32,
  parameter int          DATA_WIDTH         = 32,
  parameter int          REMAP_ADDRESS      = 0,
  parameter int          CLUSTER_ALIAS      = 1,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000
)
(
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic [3:0]                  base_addr_i,
  input  logic [5:0]                  cluster_id_i,

  // Core side
  input  logic                        data_req_i,
  input  logic [ADDR_WIDTH-1:0]       data_add_i,
  input  logic                        data_wen_i,     // 1 = load
  input  logic [DATA_WIDTH-1:0]       data_wdata_i,
  input  logic [DATA_WIDTH/8-1:0]     data_be_i,
  output logic                        data_gnt_o,
  output logic                        data_r_valid_o,
  output logic [DATA_WIDTH-1:0]       data_r_rdata_o,
  output logic                        data_r_opc_o,

  // Shared TCDM interconnect
  output logic                        data_req_sh_o,
  output logic [ADDR_WIDTH-1:0]       data_add_sh_o,
  output logic                        data_wen_sh_o,
  output logic [DATA_WIDTH-1:0]       data_wdata_sh_o,
  output logic [DATA_WIDTH/8-1:0]     data_be_sh_o,
  input  logic                        data_gnt_sh_i,
  input  logic                        data_r_valid_sh_i,
  input  logic [DATA_WIDTH-1:0]       data_r_rdata_sh_i,

  // External demux peripherals
  output logic                        data_req_ext_o,
  output logic [ADDR_WIDTH-1:0]       data_add_ext_o,
  output logic                        data_wen_ext_o,
  output logic [DATA_WIDTH-1:0]       data_wdata_ext_o,
  output logic [DATA_WIDTH/8-1:0]     data_be_ext_o,
  input  logic                        data_gnt_ext_i,
  input  logic                        data_r_valid_ext_i,
  input  logic [DATA_WIDTH-1:0]       data_r_rdata_ext_i,
  input  logic                        data_r_opc_ext_i,

  // Peripheral interconnect
  output logic                        data_req_pe_o,
  output logic [ADDR_WIDTH-1:0]       data_add_pe_o,
  output logic                        data_wen_pe_o,
  output logic [DATA_WIDTH-1:0]       data_wdata_pe_o,
  output logic [DATA_WIDTH/8-1:0]     data_be_pe_o,
  input  logic                        data_gnt_pe_i,
  input  logic                        data_r_valid_pe_i,
  input  logic [DATA_WIDTH-1:0]       data_r_rdata_pe_i,
  input  logic                        data_r_opc_pe_i,

  // Performance strobes
  output logic                        perf_l2_ld_o,
  output logic                        perf_l2_st_o,
  output logic                        perf_l2_ld_cyc_o,
  output logic                        perf_l2_st_cyc_o
);

  localparam int BE_WIDTH = DATA_WIDTH/8;

  logic [ADDR_WIDTH-1:0]  s_add;
  logic                   s_wen;
  logic [DATA_WIDTH-1:0]  s_wdata;
  logic [BE_WIDTH-1:0]    s_be;
  logic                   s_pe_req;
  logic                   s_pe_gnt;
  pdemux_pkg::dest_e      s_dest;
  logic                   s_pe_rsp_valid;
  logic [DATA_WIDTH-1:0]  s_pe_rsp_rdata;
  logic                   s_pe_rsp_opc;

  // Same payload on every target port
  assign data_add_sh_o    = s_add;
  assign data_wen_sh_o    = s_wen;
  assign data_wdata_sh_o  = s_wdata;
  assign data_be_sh_o     = s_be;
  assign data_add_ext_o   = s_add;
  assign data_wen_ext_o   = s_wen;
  assign data_wdata_ext_o = s_wdata;
  assign data_be_ext_o    = s_be;
  assign data_add_pe_o    = s_add;
  assign data_wen_pe_o    = s_wen;
  assign data_wdata_pe_o  = s_wdata;
  assign data_be_pe_o     = s_be;

  pdemux_req_router #(
    .ADDR_WIDTH         (ADDR_WIDTH),
    .DATA_WIDTH         (DATA_WIDTH),
    .BE_WIDTH           (BE_WIDTH),
    .REMAP_ADDRESS      (REMAP_ADDRESS),
    .CLUSTER_ALIAS      (CLUSTER_ALIAS),
    .CLUSTER_ALIAS_BASE (CLUSTER_ALIAS_BASE)
  ) i_req_router (
    .base_addr_i      (base_addr_i),
    .cluster_id_i     (cluster_id_i),
    .data_req_i       (data_req_i),
    .data_add_i       (data_add_i),
    .data_wen_i       (data_wen_i),
    .data_wdata_i     (data_wdata_i),
    .data_be_i        (data_be_i),
    .data_gnt_o       (data_gnt_o),
    .data_add_o       (s_add),
    .data_wen_o       (s_wen),
    .data_wdata_o     (s_wdata),
    .data_be_o        (s_be),
    .sh_req_o         (data_req_sh_o),
    .sh_gnt_i         (data_gnt_sh_i),
    .ext_req_o        (data_req_ext_o),
    .ext_gnt_i        (data_gnt_ext_i),
    .pe_req_o         (s_pe_req),
    .pe_gnt_i         (s_pe_gnt),
    .dest_o           (s_dest),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  pdemux_pe_bridge #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_pe_bridge (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .pe_req_i          (s_pe_req),
    .pe_gnt_o          (s_pe_gnt),
    .pe_port_req_o     (data_req_pe_o),
    .pe_port_gnt_i     (data_gnt_pe_i),
    .pe_port_r_valid_i (data_r_valid_pe_i),
    .pe_port_r_rdata_i (data_r_rdata_pe_i),
    .pe_port_r_opc_i   (data_r_opc_pe_i),
    .pe_rsp_valid_o    (s_pe_rsp_valid),
    .pe_rsp_rdata_o    (s_pe_rsp_rdata),
    .pe_rsp_opc_o      (s_pe_rsp_opc)
  );

  pdemux_resp_merge #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_resp_merge (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .dest_i         (s_dest),
    .sh_r_valid_i   (data_r_valid_sh_i),
    .sh_r_rdata_i   (data_r_rdata_sh_i),
    .ext_r_valid_i  (data_r_valid_ext_i),
    .ext_r_rdata_i  (data_r_rdata_ext_i),
    .ext_r_opc_i    (data_r_opc_ext_i),
    .pe_rsp_valid_i (s_pe_rsp_valid),
    .pe_rsp_rdata_i (s_pe_rsp_rdata),
    .pe_rsp_opc_i   (s_pe_rsp_opc),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o)
  );

endmodule

//--- tb_data_periph_demux.sv
`timescale 1ns/1ps

// Simple target that grants after a random delay and answers one cycle later
module target_model
#(
  parameter logic [31:0] KEY    = 32'h0,
  parameter bit          OPC_EN = 1'b0
)
(
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] add_i,
  input  logic        wen_i,
  output logic        gnt_o,
  output logic        r_valid_o,
  output logic [31:0] r_rdata_o,
  output logic        r_opc_o
);

  integer seed = 41;
  int     delay;
  int     wait_cnt;
  logic   busy;

  initial
  begin
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
  end

  always @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
      r_opc_o   <= 1'b0;
      busy      <= 1'b0;
      wait_cnt  <= 0;
    end
    else
    begin
      r_valid_o <= 1'b0;
      if (req_i && gnt_o)
      begin
        gnt_o     <= 1'b0;             // Handshake done
        busy      <= 1'b0;
        r_valid_o <= 1'b1;
        r_rdata_o <= add_i ^ KEY;
        r_opc_o   <= OPC_EN & ~wen_i;  // Stores answer with opc 1
      end
      else if (req_i && !busy)
      begin
        delay = $random(seed) & 3;
        busy <= 1'b1;
        if (delay == 0)
          gnt_o <= 1'b1;
        else
          wait_cnt <= delay - 1;
      end
      else if (req_i && !gnt_o)
      begin
        if (wait_cnt == 0)
          gnt_o <= 1'b1;
        else
          wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

module tb_data_periph_demux;

  localparam logic [31:0] KEY_SH  = 32'h0000_5A5A;
  localparam logic [31:0] KEY_EXT = 32'h0000_3C3C;
  localparam logic [31:0] KEY_PE  = 32'h0000_0F0F;

  logic        clk = 1'b0;
  logic        rst_ni;
  logic [3:0]  base_addr_i;
  logic [5:0]  cluster_id_i;
  logic        data_req_i;
  logic [31:0] data_add_i;
  logic        data_wen_i;
  logic [31:0] data_wdata_i;
  logic [3:0]  data_be_i;
  logic        data_gnt_o, data_r_valid_o, data_r_opc_o;
  logic [31:0] data_r_rdata_o;
  logic        data_req_sh_o, data_wen_sh_o, data_gnt_sh_i, data_r_valid_sh_i;
  logic [31:0] data_add_sh_o, data_wdata_sh_o, data_r_rdata_sh_i;
  logic [3:0]  data_be_sh_o, data_be_ext_o, data_be_pe_o;
  logic        data_req_ext_o, data_wen_ext_o, data_gnt_ext_i, data_r_valid_ext_i;
  logic [31:0] data_add_ext_o, data_wdata_ext_o, data_r_rdata_ext_i;
  logic        data_r_opc_ext_i;
  logic        data_req_pe_o, data_wen_pe_o, data_gnt_pe_i, data_r_valid_pe_i;
  logic [31:0] data_add_pe_o, data_wdata_pe_o, data_r_rdata_pe_i;
  logic        data_r_opc_pe_i;
  logic        perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;

  // Trace columns
  logic [3:0]  tr_base  [0:63];
  logic [5:0]  tr_cid   [0:63];
  logic [31:0] tr_addr  [0:63];
  logic        tr_wen   [0:63];
  logic [31:0] tr_wdata [0:63];
  logic [1:0]  tr_dest  [0:63];
  logic [31:0] tr_rdata [0:63];
  logic        tr_opc   [0:63];

  int n_tests = 0;
  int errors = 0;
  int ld_pulses = 0;
  int st_pulses = 0;

  always #10 clk = ~clk;

  data_periph_demux #(
    .ADDR_WIDTH         (32),
    .DATA_WIDTH         (32),
    .REMAP_ADDRESS      (1),
    .CLUSTER_ALIAS      (1),
    .CLUSTER_ALIAS_BASE (12'h000)
  ) i_data_periph_demux (
    .clk (clk), .rst_ni (rst_ni),
    .base_addr_i (base_addr_i), .cluster_id_i (cluster_id_i),
    .data_req_i (data_req_i), .data_add_i (data_add_i), .data_wen_i (data_wen_i),
    .data_wdata_i (data_wdata_i), .data_be_i (data_be_i), .data_gnt_o (data_gnt_o),
    .data_r_valid_o (data_r_valid_o), .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o (data_r_opc_o),
    .data_req_sh_o (data_req_sh_o), .data_add_sh_o (data_add_sh_o),
    .data_wen_sh_o (data_wen_sh_o), .data_wdata_sh_o (data_wdata_sh_o),
    .data_be_sh_o (data_be_sh_o), .data_gnt_sh_i (data_gnt_sh_i),
    .data_r_valid_sh_i (data_r_valid_sh_i), .data_r_rdata_sh_i (data_r_rdata_sh_i),
    .data_req_ext_o (data_req_ext_o), .data_add_ext_o (data_add_ext_o),
    .data_wen_ext_o (data_wen_ext_o), .data_wdata_ext_o (data_wdata_ext_o),
    .data_be_ext_o (data_be_ext_o), .data_gnt_ext_i (data_gnt_ext_i),
    .data_r_valid_ext_i (data_r_valid_ext_i), .data_r_rdata_ext_i (data_r_rdata_ext_i),
    .data_r_opc_ext_i (data_r_opc_ext_i),
    .data_req_pe_o (data_req_pe_o), .data_add_pe_o (data_add_pe_o),
    .data_wen_pe_o (data_wen_pe_o), .data_wdata_pe_o (data_wdata_pe_o),
    .data_be_pe_o (data_be_pe_o), .data_gnt_pe_i (data_gnt_pe_i),
    .data_r_valid_pe_i (data_r_valid_pe_i), .data_r_rdata_pe_i (data_r_rdata_pe_i),
    .data_r_opc_pe_i (data_r_opc_pe_i),
    .perf_l2_ld_o (perf_l2_ld_o), .perf_l2_st_o (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o), .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  target_model #(.KEY (KEY_SH), .OPC_EN (1'b0)) i_sh_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (data_req_sh_o), .add_i (data_add_sh_o),
    .wen_i (data_wen_sh_o), .gnt_o (data_gnt_sh_i), .r_valid_o (data_r_valid_sh_i),
    .r_rdata_o (data_r_rdata_sh_i), .r_opc_o ()
  );

  target_model #(.KEY (KEY_EXT), .OPC_EN (1'b1)) i_ext_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (data_req_ext_o), .add_i (data_add_ext_o),
    .wen_i (data_wen_ext_o), .gnt_o (data_gnt_ext_i), .r_valid_o (data_r_valid_ext_i),
    .r_rdata_o (data_r_rdata_ext_i), .r_opc_o (data_r_opc_ext_i)
  );

  target_model #(.KEY (KEY_PE), .OPC_EN (1'b1)) i_pe_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (data_req_pe_o), .add_i (data_add_pe_o),
    .wen_i (data_wen_pe_o), .gnt_o (data_gnt_pe_i), .r_valid_o (data_r_valid_pe_i),
    .r_rdata_o (data_r_rdata_pe_i), .r_opc_o (data_r_opc_pe_i)
  );

  // Count grant strobes over the whole run
  always @(posedge clk)
  begin
    if (perf_l2_ld_o)
      ld_pulses <= ld_pulses + 1;
    if (perf_l2_st_o)
      st_pulses <= st_pulses + 1;
  end

  //****************************************
  // Helpers
  //****************************************
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Top nibble swap between base and 0x1
  function automatic logic [31:0] remap_addr(input logic [3:0] base, input logic [31:0] a);
    logic [3:0] top;
    top = a[31:28];
    if (top == base)
      top = 4'h1;
    else if (top == 4'h1)
      top = base;
    return {top, a[27:0]};
  endfunction

  task automatic check_idle();
    check_value("data_gnt_o", 0, data_gnt_o);
    check_value("data_r_valid_o", 0, data_r_valid_o);
    check_value("target req", 0, {data_req_sh_o, data_req_ext_o, data_req_pe_o});
  endtask

  task automatic load_trace();
    int    fd;
    int    cnt;
    string line;
    logic [31:0] f [0:7];
    fd = $fopen("demux_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open demux_trace.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;   // Column notes and blank lines
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
      if (cnt != 8)
        continue;
      tr_base[n_tests]  = f[0][3:0];
      tr_cid[n_tests]   = f[1][5:0];
      tr_addr[n_tests]  = f[2];
      tr_wen[n_tests]   = f[3][0];
      tr_wdata[n_tests] = f[4];
      tr_dest[n_tests]  = f[5][1:0];
      tr_rdata[n_tests] = f[6];
      tr_opc[n_tests]   = f[7][0];
      n_tests++;
    end
    $fclose(fd);
  endtask

  //****************************************
  // One request from issue to response
  //****************************************
  task automatic run_request(input int idx);
    int cyc, limit, pe_rv_cyc, gnt_cyc, rsp_cyc, rsp_cnt, pe_hs, err_before;
    logic seen_sh, seen_ext, seen_pe, granted, l2;
    logic [31:0] exp_add;
    logic [3:0] exp_be;
    logic [1:0] seen_dest;
    err_before = errors;
    exp_add = remap_addr(tr_base[idx], tr_addr[idx]);
    exp_be = 4'(idx + 1);
    l2 = (tr_dest[idx] != 2'd0);
    {cyc, pe_rv_cyc, gnt_cyc, rsp_cyc, rsp_cnt, pe_hs} = '0;
    {seen_sh, seen_ext, seen_pe, granted} = '0;
    limit = 60;
    @(posedge clk);
    base_addr_i  <= tr_base[idx];
    cluster_id_i <= tr_cid[idx];
    data_req_i   <= 1'b1;
    data_add_i   <= tr_addr[idx];
    data_wen_i   <= tr_wen[idx];
    data_wdata_i <= tr_wdata[idx];
    data_be_i    <= exp_be;
    while (cyc < limit)
    begin
      @(posedge clk);
      cyc++;
      if (!granted)
      begin
        if (data_req_sh_o + data_req_ext_o + data_req_pe_o > 1)
        begin
          $display("More than one target request at %0t ns", $time);
          errors++;
        end
        if (data_req_sh_o)
          check_value("data_add_sh_o", exp_add, data_add_sh_o);
        if (data_req_ext_o)
          check_value("data_add_ext_o", exp_add, data_add_ext_o);
        if (data_req_pe_o)
          check_value("data_add_pe_o", exp_add, data_add_pe_o);
        // Payload reaches every target port
        check_value("data_wen_sh_o", tr_wen[idx], data_wen_sh_o);
        check_value("data_wen_ext_o", tr_wen[idx], data_wen_ext_o);
        check_value("data_wen_pe_o", tr_wen[idx], data_wen_pe_o);
        check_value("data_wdata_sh_o", tr_wdata[idx], data_wdata_sh_o);
        check_value("data_wdata_ext_o", tr_wdata[idx], data_wdata_ext_o);
        check_value("data_wdata_pe_o", tr_wdata[idx], data_wdata_pe_o);
        check_value("data_be_sh_o", exp_be, data_be_sh_o);
        check_value("data_be_ext_o", exp_be, data_be_ext_o);
        check_value("data_be_pe_o", exp_be, data_be_pe_o);
        seen_sh  |= data_req_sh_o;
        seen_ext |= data_req_ext_o;
        seen_pe  |= data_req_pe_o;
        if (pe_hs > 0)
          check_value("data_req_pe_o", 0, data_req_pe_o);   // One PE request at a time
        if (data_req_pe_o && data_gnt_pe_i)
          pe_hs++;
        check_value("perf_l2_ld_cyc_o", l2 & tr_wen[idx], perf_l2_ld_cyc_o);
        check_value("perf_l2_st_cyc_o", l2 & ~tr_wen[idx], perf_l2_st_cyc_o);
      end
      else
        check_value("target req", 0, {data_req_sh_o, data_req_ext_o, data_req_pe_o});
      if (data_r_valid_pe_i)
        pe_rv_cyc = cyc;
      if (data_gnt_o && !granted)
      begin
        granted = 1'b1;
        gnt_cyc = cyc;
        data_req_i <= 1'b0;   // Core drops the request once granted
      end
      if (data_r_valid_o)
      begin
        rsp_cnt++;
        if (rsp_cnt == 1)
        begin
          rsp_cyc = cyc;
          limit   = cyc + 2;  // Watch for a duplicate pulse
          check_value("data_r_rdata_o", tr_rdata[idx], data_r_rdata_o);
          check_value("data_r_opc_o", tr_opc[idx], data_r_opc_o);
        end
      end
    end
    if (seen_sh + seen_ext + seen_pe != 1)
      seen_dest = 2'd3;   // None or several targets
    else
      seen_dest = seen_sh ? 2'd0 : (seen_pe ? 2'd1 : 2'd2);
    check_value("destination", tr_dest[idx], seen_dest);
    check_value("response count", 1, rsp_cnt);
    if (!granted)
    begin
      $display("Request %0d was never granted", idx);
      errors++;
    end
    if (tr_dest[idx] == 2'd1)
    begin
      check_value("PE grant delay", 1, gnt_cyc - pe_rv_cyc);
      check_value("PE response delay", 2, rsp_cyc - pe_rv_cyc);
      check_value("PE handshakes", 1, pe_hs);
    end
    else
      check_value("PE handshakes", 0, pe_hs);
    $display("test %0d dest %0d %s", idx, tr_dest[idx],
             (errors == err_before) ? "ok" : "failed");
  endtask

  //****************************************
  // Main sequence and watchdog
  //****************************************
  initial
  begin
    int exp_ld;
    int exp_st;
    exp_ld = 0;
    exp_st = 0;
    rst_ni       = 1'b0;
    base_addr_i  = 4'h1;
    cluster_id_i = '0;
    data_req_i   = 1'b0;
    data_add_i   = '0;
    data_wen_i   = 1'b1;
    data_wdata_i = '0;
    data_be_i    = 4'hF;
    load_trace();
    repeat (8)
    begin
      @(posedge clk);
      check_idle();
    end
    rst_ni <= 1'b1;
    @(posedge clk);
    check_idle();
    for (int i = 0; i < n_tests; i++)
    begin
      run_request(i);
      if (tr_dest[i] != 2'd0)
      begin
        exp_ld += tr_wen[i];
        exp_st += !tr_wen[i];
      end
    end
    @(posedge clk);
    check_value("perf_l2_ld_o pulses", exp_ld, ld_pulses);
    check_value("perf_l2_st_o pulses", exp_st, st_pulses);
    $display("tests %0d, errors %0d", n_tests, errors);
    if (errors == 0 && n_tests > 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    @(posedge rst_ni);   // Trace fully loaded by the end of reset
    #((n_tests * 40 + 20) * 20);
    $display("Timeout: the trace did not complete in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- demux_trace.txt
# base cluster_id address wen wdata dest(0=SH 1=PE 2=EXT) exp_rdata exp_opc
# all fields hex, response data is the target address XOR the target key
1 0 10000010 1 00000000 0 10005A4A 0
1 0 10100020 0 11112222 0 10105A7A 0
1 0 10204008 1 00000000 2 10207C34 0
1 0 10204100 0 33334444 2 10207D3C 1
1 0 10200100 1 00000000 1 10200E0F 0
1 0 1A000000 0 55556666 1 1A000F0F 1
1 0 00000040 1 00000000 0 00005A1A 0
1 0 00204000 0 77778888 2 00207C3C 1
1 3 10C00004 1 00000000 0 10C05A5E 0
1 3 10E04000 1 00000000 2 10E07C3C 0
1 3 10000000 1 00000000 1 10000F0F 0
A 0 10000080 1 00000000 0 A0005ADA 0
A 0 A0000080 0 9999AAAA 1 10000F8F 1
A 0 10204010 1 00000000 2 A0207C2C 0
A 1 30040000 0 BBBBCCCC 1 30040F0F 1
A 1 10400008 0 DDDDEEEE 0 A0405A52 0
A 1 10600200 1 00000000 1 A0600D0F 0
A 1 1060C000 0 12345678 2 A060FC3C 1
1 0 20001234 1 00000000 1 20001D3B 0
1 0 1010FFFC 1 00000000 0 1010A5A6 0

//--- project.f
pdemux_pkg.sv
pdemux_req_router.sv
pdemux_pe_bridge.sv
pdemux_resp_merge.sv
data_periph_demux.sv
tb_data_periph_demux.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_data_periph_demux \
  -f project.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "SIMULATION PASSED" sim.log
